//--- rtl/alu_func_pkg.sv
package alu_func_pkg;

  localparam int BYTE_W = 8;   // narrow datapath width
  localparam int WORD_W = 16;  // wide datapath width

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [WORD_W-1:0] word_t;

  // operation codes, arithmetic first, then logic, then rotates
  typedef enum logic [3:0] {
    ALU_FUNC_ADD = 4'd0,
    ALU_FUNC_ADC = 4'd1,
    ALU_FUNC_SUB = 4'd2,
    ALU_FUNC_SBC = 4'd3,
    ALU_FUNC_AND = 4'd4,
    ALU_FUNC_XOR = 4'd5,
    ALU_FUNC_OR  = 4'd6,
    ALU_FUNC_CP  = 4'd7,
    ALU_FUNC_RR  = 4'd8,
    ALU_FUNC_RRC = 4'd9,
    ALU_FUNC_RL  = 4'd10,
    ALU_FUNC_RLC = 4'd11
  } alu_func_e;

endpackage

//--- rtl/alu_flags_pkg.sv
package alu_flags_pkg;

  // z80 flag register layout, msb first: S Z 5 H 3 V N C
  typedef logic [7:0] flags_t;

  localparam int FLAG_S = 7;  // sign
  localparam int FLAG_Z = 6;  // zero
  localparam int FLAG_5 = 5;  // undocumented, passed through
  localparam int FLAG_H = 4;  // half carry
  localparam int FLAG_3 = 3;  // undocumented, passed through
  localparam int FLAG_V = 2;  // overflow or parity
  localparam int FLAG_N = 1;  // subtract
  localparam int FLAG_C = 0;  // carry

endpackage

//--- rtl/alu_adder.sv
`timescale 1ns/1ps

module alu_adder #(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             cin,
  output logic [WIDTH-1:0] sum,
  output logic             half,
  output logic             carry,
  output logic             ovf
);

  // half carry comes out of bit 3 for 8 bits, bit 11 for 16 bits
  localparam int HALF_W = WIDTH - 4;

  logic [WIDTH:0]   full;  // sum with carry out
  logic [WIDTH-1:0] low;   // sum of all but the top bit
  logic [HALF_W:0]  nib;   // sum below the half carry point

  assign full = {1'b0, a} + {1'b0, b} + {{WIDTH{1'b0}}, cin};
  assign low  = {1'b0, a[WIDTH-2:0]} + {1'b0, b[WIDTH-2:0]} + {{(WIDTH-1){1'b0}}, cin};
  assign nib  = {1'b0, a[HALF_W-1:0]} + {1'b0, b[HALF_W-1:0]} + {{HALF_W{1'b0}}, cin};

  assign sum   = full[WIDTH-1:0];
  assign carry = full[WIDTH];
  assign half  = nib[HALF_W];
  assign ovf   = full[WIDTH] ^ low[WIDTH-1];  // carry out vs carry into top bit

endmodule

//--- rtl/alu8.sv
`timescale 1ns/1ps

module alu8
  import alu_func_pkg::*, alu_flags_pkg::*;
(
  input  alu_func_e func,
  input  byte_t     x,
  input  byte_t     y,
  input  flags_t    f_in,
  output byte_t     out,
  output flags_t    f
);

  logic  sub_op;
  byte_t add_b;
  logic  add_cin;
  byte_t sum;
  logic  half;
  logic  carry;
  logic  ovf;

  logic  h;
  logic  v;
  logic  n;
  logic  c;
  logic  par;    // v reports parity of the result
  logic  known;  // code is valid for this datapath

  assign sub_op = func inside {ALU_FUNC_SUB, ALU_FUNC_SBC, ALU_FUNC_CP};
  assign add_b  = sub_op ? ~y : y;

  always_comb begin
    case (func)
      ALU_FUNC_ADC: add_cin = f_in[FLAG_C];
      ALU_FUNC_SUB: add_cin = 1'b1;
      ALU_FUNC_CP:  add_cin = 1'b1;
      ALU_FUNC_SBC: add_cin = ~f_in[FLAG_C];  // inverted borrow
      default:      add_cin = 1'b0;
    endcase
  end

  alu_adder #(.WIDTH(BYTE_W)) u_adder (
    .a     (x),
    .b     (add_b),
    .cin   (add_cin),
    .sum   (sum),
    .half  (half),
    .carry (carry),
    .ovf   (ovf)
  );

  always_comb begin
    out   = x;
    h     = 1'b0;
    v     = 1'b0;
    n     = 1'b0;
    c     = 1'b0;
    par   = 1'b0;
    known = 1'b1;
    case (func)
      ALU_FUNC_ADD, ALU_FUNC_ADC, ALU_FUNC_SUB, ALU_FUNC_SBC, ALU_FUNC_CP: begin
        out = sum;
        h   = half;
        v   = ovf;
        n   = sub_op;
        c   = carry;
      end
      ALU_FUNC_AND: begin
        out = x & y;
        h   = 1'b1;
        par = 1'b1;
      end
      ALU_FUNC_XOR: begin
        out = x ^ y;
        par = 1'b1;
      end
      ALU_FUNC_OR: begin
        out = x | y;
        par = 1'b1;
      end
      ALU_FUNC_RR: begin
        out = {f_in[FLAG_C], x[7:1]};
        c   = x[0];
        par = 1'b1;
      end
      ALU_FUNC_RRC: begin
        out = {x[0], x[7:1]};
        c   = x[0];
        par = 1'b1;
      end
      ALU_FUNC_RL: begin
        out = {x[6:0], f_in[FLAG_C]};
        c   = x[7];
        par = 1'b1;
      end
      ALU_FUNC_RLC: begin
        out = {x[6:0], x[7]};
        c   = x[7];
        par = 1'b1;
      end
      default: known = 1'b0;
    endcase
    if (par) begin
      v = ~^out;  // set on even parity
    end

    f = f_in;  // bits 5 and 3 always pass through
    if (known) begin
      f[FLAG_S] = out[BYTE_W-1];
      f[FLAG_Z] = (out == '0);
      f[FLAG_H] = h;
      f[FLAG_V] = v;
      f[FLAG_N] = n;
      f[FLAG_C] = c;
    end
  end

endmodule

//--- rtl/alu16.sv
`timescale 1ns/1ps

module alu16
  import alu_func_pkg::*, alu_flags_pkg::*;
(
  input  alu_func_e func,
  input  word_t     x,
  input  word_t     y,
  input  flags_t    f_in,
  output word_t     out,
  output flags_t    f
);

  logic  arith;
  logic  sub_op;
  logic  add_cin;
  word_t sum;
  logic  half;
  logic  carry;
  logic  ovf;

  assign arith  = func inside {ALU_FUNC_ADD, ALU_FUNC_ADC, ALU_FUNC_SUB,
                               ALU_FUNC_SBC, ALU_FUNC_CP};
  assign sub_op = func inside {ALU_FUNC_SUB, ALU_FUNC_SBC, ALU_FUNC_CP};

  always_comb begin
    case (func)
      ALU_FUNC_ADC: add_cin = f_in[FLAG_C];
      ALU_FUNC_SUB: add_cin = 1'b1;
      ALU_FUNC_CP:  add_cin = 1'b1;
      ALU_FUNC_SBC: add_cin = ~f_in[FLAG_C];
      default:      add_cin = 1'b0;
    endcase
  end

  alu_adder #(.WIDTH(WORD_W)) u_adder (
    .a     (x),
    .b     (sub_op ? ~y : y),
    .cin   (add_cin),
    .sum   (sum),
    .half  (half),
    .carry (carry),
    .ovf   (ovf)
  );

  // logic and rotate codes have no 16-bit form, x and F go back untouched
  assign out = arith ? sum : x;

  always_comb begin
    f = f_in;
    if (arith) begin
      f[FLAG_S] = sum[WORD_W-1];
      f[FLAG_Z] = (sum == '0);
      f[FLAG_H] = half;  // carry out of bit 11
      f[FLAG_V] = ovf;
      f[FLAG_N] = sub_op;
      f[FLAG_C] = carry;
    end
  end

endmodule

//--- rtl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit
  import alu_func_pkg::*, alu_flags_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,

  input  logic      in_valid,
  output logic      in_ready,
  input  alu_func_e func,
  input  logic      wide,
  input  word_t     x,
  input  word_t     y,

  input  logic      f_load,
  input  flags_t    f_data,

  output logic      out_valid,
  input  logic      out_ready,
  output word_t     result,
  output flags_t    flags
);

  flags_t f_reg;  // architectural F

  byte_t  out8;
  flags_t f8;
  word_t  out16;
  flags_t f16;

  word_t  sel_result;
  flags_t sel_flags;
  logic   accept;

  alu8 u_alu8 (
    .func (func),
    .x    (x[BYTE_W-1:0]),
    .y    (y[BYTE_W-1:0]),
    .f_in (f_reg),
    .out  (out8),
    .f    (f8)
  );

  alu16 u_alu16 (
    .func (func),
    .x    (x),
    .y    (y),
    .f_in (f_reg),
    .out  (out16),
    .f    (f16)
  );

  assign sel_result = wide ? out16 : {{(WORD_W-BYTE_W){1'b0}}, out8};  // narrow is zero-extended
  assign sel_flags  = wide ? f16 : f8;

  // room when empty or draining this cycle, and no flag load in progress
  assign in_ready = (~out_valid | out_ready) & ~f_load;
  assign accept   = in_valid & in_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      f_reg <= '0;
    end else if (f_load) begin
      f_reg <= f_data;
    end else if (accept) begin
      f_reg <= sel_flags;  // next request sees the new carry
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      result <= sel_result;
      flags  <= sel_flags;
    end
  end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 4,  // ns, gives an 8 ns clock
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);  // release away from the active edge
    arst_n = 1'b1;
  end

endmodule

//--- dv/alu_unit_assert.sv
`timescale 1ns/1ps

module alu_unit_assert
  import alu_func_pkg::*, alu_flags_pkg::*;
(
  input logic   clk,
  input logic   arst_n,
  input logic   in_valid,
  input logic   in_ready,
  input logic   f_load,
  input logic   out_valid,
  input logic   out_ready,
  input word_t  result,
  input flags_t flags
);

  reset_clears_valid: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else $error("out_valid is high while reset is asserted");

  stall_holds_output: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(result) && $stable(flags)))
    else $error("response changed while it was stalled");

  load_blocks_request: assert property (@(posedge clk) disable iff (!arst_n)
    f_load |-> !in_ready)
    else $error("in_ready is high during a flag load");

  accept_gives_valid: assert property (@(posedge clk) disable iff (!arst_n)
    (in_valid && in_ready) |=> out_valid)
    else $error("out_valid did not follow an accepted request");

  valid_needs_accept: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(out_valid) |-> $past(in_valid && in_ready))
    else $error("out_valid rose without an accepted request");

endmodule

//--- dv/alu_unit_tb.sv
`timescale 1ns/1ps

module alu_unit_tb
  import alu_func_pkg::*, alu_flags_pkg::*;
();

  localparam int NUM_ROWS = 22;
  localparam int TIMEOUT  = 50;  // cycles per wait
  localparam logic [31:0] SEED = 32'hc0e3_a901;

  logic      clk;
  logic      arst_n;
  logic      in_valid;
  logic      in_ready;
  alu_func_e func;
  logic      wide;
  word_t     x;
  word_t     y;
  logic      f_load;
  flags_t    f_data;
  logic      out_valid;
  logic      out_ready;
  word_t     result;
  flags_t    flags;

  // stimulus table with one entry per request
  flags_t    row_pre   [NUM_ROWS];
  alu_func_e row_func  [NUM_ROWS];
  logic      row_wide  [NUM_ROWS];
  word_t     row_x     [NUM_ROWS];
  word_t     row_y     [NUM_ROWS];
  word_t     row_res   [NUM_ROWS];
  flags_t    row_flg   [NUM_ROWS];
  logic      row_chain [NUM_ROWS];  // keep F from the previous row
  int        row_count = 0;

  int accept_count = 0;
  int resp_count   = 0;
  int value_errs   = 0;
  int proto_errs   = 0;
  int timeout_errs = 0;

  tb_clk_gen u_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  alu_unit u_alu_unit (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .func      (func),
    .wide      (wide),
    .x         (x),
    .y         (y),
    .f_load    (f_load),
    .f_data    (f_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result),
    .flags     (flags)
  );

  bind alu_unit alu_unit_assert u_alu_unit_assert (.*);

  task automatic add_row(input flags_t pre, input alu_func_e fn, input logic wd,
                         input word_t a, input word_t b, input word_t res,
                         input flags_t flg, input logic chain);
    row_pre[row_count]   = pre;
    row_func[row_count]  = fn;
    row_wide[row_count]  = wd;
    row_x[row_count]     = a;
    row_y[row_count]     = b;
    row_res[row_count]   = res;
    row_flg[row_count]   = flg;
    row_chain[row_count] = chain;
    row_count++;
  endtask

  // flags in S Z 5 H 3 V N C order
  task automatic build_table();
    add_row(8'h00, ALU_FUNC_ADD, 1'b0, 16'h007F, 16'h0001, 16'h0080, 8'h94, 1'b0);
    add_row(8'h28, ALU_FUNC_ADD, 1'b0, 16'h00FF, 16'h0001, 16'h0000, 8'h79, 1'b0);
    add_row(8'h01, ALU_FUNC_ADC, 1'b0, 16'h0010, 16'h0020, 16'h0031, 8'h00, 1'b0);
    add_row(8'h00, ALU_FUNC_SUB, 1'b0, 16'h0080, 16'h0001, 16'h007F, 8'h07, 1'b0);
    add_row(8'h28, ALU_FUNC_SUB, 1'b0, 16'h0000, 16'h0001, 16'h00FF, 8'hAA, 1'b0);
    add_row(8'h01, ALU_FUNC_SBC, 1'b0, 16'h0005, 16'h0002, 16'h0002, 8'h13, 1'b0);
    add_row(8'h00, ALU_FUNC_CP,  1'b0, 16'h0042, 16'h0042, 16'h0000, 8'h53, 1'b0);
    add_row(8'h28, ALU_FUNC_AND, 1'b0, 16'h00F0, 16'h003C, 16'h0030, 8'h3C, 1'b0);
    add_row(8'h01, ALU_FUNC_XOR, 1'b0, 16'h12FF, 16'h34FE, 16'h0001, 8'h00, 1'b0);
    add_row(8'h00, ALU_FUNC_OR,  1'b0, 16'h0000, 16'h0000, 16'h0000, 8'h44, 1'b0);
    add_row(8'h00, ALU_FUNC_OR,  1'b0, 16'h0080, 16'h0001, 16'h0081, 8'h84, 1'b0);
    add_row(8'h01, ALU_FUNC_RR,  1'b0, 16'h0002, 16'h0000, 16'h0081, 8'h84, 1'b0);
    add_row(8'h29, ALU_FUNC_RRC, 1'b0, 16'h0002, 16'h0000, 16'h0001, 8'h28, 1'b0);
    add_row(8'h00, ALU_FUNC_RL,  1'b0, 16'h0080, 16'h0000, 16'h0000, 8'h45, 1'b0);
    add_row(8'h00, ALU_FUNC_RLC, 1'b0, 16'h0081, 16'h0000, 16'h0003, 8'h05, 1'b0);
    add_row(8'h00, ALU_FUNC_ADD, 1'b1, 16'h7FFF, 16'h0001, 16'h8000, 8'h94, 1'b0);
    add_row(8'h28, ALU_FUNC_SUB, 1'b1, 16'h0000, 16'h0001, 16'hFFFF, 8'hAA, 1'b0);
    add_row(8'h01, ALU_FUNC_ADC, 1'b1, 16'h1234, 16'h0FFF, 16'h2234, 8'h10, 1'b0);
    add_row(8'h01, ALU_FUNC_SBC, 1'b1, 16'h1000, 16'h0001, 16'h0FFE, 8'h03, 1'b0);
    add_row(8'h5A, ALU_FUNC_XOR, 1'b1, 16'hABCD, 16'h1111, 16'hABCD, 8'h5A, 1'b0);
    add_row(8'h00, ALU_FUNC_ADD, 1'b0, 16'h00FF, 16'h0001, 16'h0000, 8'h51, 1'b0);
    add_row(8'h00, ALU_FUNC_ADC, 1'b0, 16'h0000, 16'h0000, 16'h0001, 8'h00, 1'b1);
  endtask

  task automatic load_flags(input flags_t value);
    f_load = 1'b1;
    f_data = value;
    @(negedge clk);
    f_load = 1'b0;
  endtask

  task automatic send_request(input int idx, output logic ok);
    int waited;
    ok = 1'b0;
    waited = 0;
    in_valid = 1'b1;
    func = row_func[idx];
    wide = row_wide[idx];
    x = row_x[idx];
    y = row_y[idx];
    while (!ok && waited < TIMEOUT) begin
      @(posedge clk);
      if (in_ready) begin
        ok = 1'b1;
        accept_count++;
      end else begin
        waited++;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    if (!ok) begin
      timeout_errs++;
      $display("Timeout: request %0d was never accepted", idx);
    end else begin
      waited = 0;
      while (!out_valid && waited < TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      if (!out_valid) begin
        ok = 1'b0;
        timeout_errs++;
        $display("Timeout: no response became valid for request %0d", idx);
      end
    end
  endtask

  task automatic check_response();
    assert (resp_count < accept_count) else begin
      proto_errs++;
      $display("Response at %0t arrived with no request outstanding", $time);
    end
    if (resp_count < row_count) begin
      assert (result == row_res[resp_count]) else begin
        value_errs++;
        $display("Error at %0t: result expected 16'h%04h, actual 16'h%04h (row %0d)",
                 $time, row_res[resp_count], result, resp_count);
      end
      assert (flags == row_flg[resp_count]) else begin
        value_errs++;
        $display("Error at %0t: flags expected 8'h%02h, actual 8'h%02h (row %0d)",
                 $time, row_flg[resp_count], flags, resp_count);
      end
    end
    resp_count++;
  endtask

  // responses are checked in order at each drain edge
  always @(posedge clk) begin
    if (arst_n && out_valid) begin
      if (out_ready) begin
        check_response();
      end else begin
        assert (!in_ready) else begin
          proto_errs++;
          $display("Error at %0t: in_ready expected 0 while stalled, actual %b",
                   $time, in_ready);
        end
      end
    end
  end

  initial begin : ready_stall
    int stall_cnt;
    stall_cnt = 0;
    out_ready = 1'b1;
    void'($urandom(SEED));
    forever begin
      @(negedge clk);
      if (stall_cnt > 0) begin
        out_ready = 1'b0;
        stall_cnt--;
      end else begin
        out_ready = 1'b1;
        if ($urandom % 3 == 0) begin
          stall_cnt = int'($urandom % 6) + 1;
        end
      end
    end
  end

  task automatic finish_run();
    $display("error counts: value %0d, protocol %0d, timeout %0d",
             value_errs, proto_errs, timeout_errs);
    if (value_errs + proto_errs + timeout_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  initial begin
    int   waited;
    logic ok;
    in_valid = 1'b0;
    func = ALU_FUNC_ADD;
    wide = 1'b0;
    x = '0;
    y = '0;
    f_load = 1'b0;
    f_data = '0;
    ok = 1'b1;
    waited = 0;
    build_table();
    while (arst_n !== 1'b1 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (arst_n !== 1'b1) begin
      ok = 1'b0;
      timeout_errs++;
      $display("Timeout: reset was never released");
    end
    @(negedge clk);
    for (int i = 0; i < row_count && ok; i++) begin
      if (!row_chain[i]) begin
        load_flags(row_pre[i]);
      end
      send_request(i, ok);
    end
    waited = 0;
    while (resp_count < accept_count && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (resp_count < accept_count) begin
      timeout_errs++;
      $display("Timeout: %0d responses still missing", accept_count - resp_count);
    end
    assert (resp_count == NUM_ROWS) else begin
      proto_errs++;
      $display("Error at %0t: response count expected %0d, actual %0d",
               $time, NUM_ROWS, resp_count);
    end
    finish_run();
  end

endmodule

//--- sources.f
rtl/alu_func_pkg.sv
rtl/alu_flags_pkg.sv
rtl/alu_adder.sv
rtl/alu8.sv
rtl/alu16.sv
rtl/alu_unit.sv
dv/tb_clk_gen.sv
dv/alu_unit_assert.sv
dv/alu_unit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the alu_unit testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module alu_unit_tb -f sources.f \
  && ./obj_dir/Valu_unit_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Finished with no errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
